// File: icache.f
src/icache_pkg.sv
src/axi_rd_if.sv
src/icache_tag_array.sv
src/icache_data_way.sv
src/icache.sv
src/axi_burst_mem.sv
src/icache_subsys.sv
verif/icache_sva.sv
verif/icache_tb.sv

// File: Makefile
# Verilator build and run for the instruction cache testbench

VERILATOR ?= verilator
TOP ?= icache_tb
FILELIST ?= icache.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
SIM_ARGS ?= +verilator+error+limit+100

SOURCES := $(wildcard src/*.sv verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides, the simulator's own exit status is not trusted
run: compile
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tb;
	import icache_pkg::*;

	localparam int CLK_HALF = 20;
	// deeper than the default so five lines of one set fit without aliasing
	localparam int MEM_WORDS = 2048;
	localparam int MEM_LATENCY = 3;
	localparam int MEM_AW = $clog2(MEM_WORDS);
	// a refill ends long before this many request pulses
	localparam int MAX_TRIES = MEM_LATENCY + 4;

	localparam logic [1:0] OP_STORE = 2'd0;
	localparam logic [1:0] OP_FETCH = 2'd1;
	localparam logic [1:0] OP_FLUSH = 2'd2;
	// expected lookup outcome of a fetch
	localparam logic [1:0] EX_ANY = 2'd0;
	localparam logic [1:0] EX_HIT = 2'd1;
	localparam logic [1:0] EX_MISS = 2'd2;

	localparam int N_OPS = 32;
	localparam int WATCHDOG_CYCLES = N_OPS * (MEM_LATENCY + 12) + 20;

	// entry is {operation, expected outcome, byte address}
	localparam logic [35:0] OPS [N_OPS] = '{
		// line 0x200, all four words stored
		{OP_STORE, EX_ANY, 32'h0000_0200},
		{OP_STORE, EX_ANY, 32'h0000_0204},
		{OP_STORE, EX_ANY, 32'h0000_0208},
		{OP_STORE, EX_ANY, 32'h0000_020c},
		// first fetch refills, the other words come from the new line
		{OP_FETCH, EX_MISS, 32'h0000_0204},
		{OP_FETCH, EX_HIT, 32'h0000_0200},
		{OP_FETCH, EX_HIT, 32'h0000_0208},
		{OP_FETCH, EX_HIT, 32'h0000_020c},
		// whole line again, reverse order
		{OP_FETCH, EX_HIT, 32'h0000_020c},
		{OP_FETCH, EX_HIT, 32'h0000_0208},
		{OP_FETCH, EX_HIT, 32'h0000_0204},
		{OP_FETCH, EX_HIT, 32'h0000_0200},
		// store drops the cached copy, refill brings the new word
		{OP_STORE, EX_ANY, 32'h0000_0208},
		{OP_FETCH, EX_MISS, 32'h0000_0208},
		{OP_FETCH, EX_HIT, 32'h0000_0200},
		// flushed hit, then the same fetch without flush
		{OP_FLUSH, EX_HIT, 32'h0000_0204},
		{OP_FETCH, EX_HIT, 32'h0000_0204},
		// five lines of set 10, one more than there are ways
		{OP_STORE, EX_ANY, 32'h0000_00a4},
		{OP_STORE, EX_ANY, 32'h0000_04a4},
		{OP_STORE, EX_ANY, 32'h0000_08a4},
		{OP_STORE, EX_ANY, 32'h0000_0ca4},
		{OP_STORE, EX_ANY, 32'h0000_10a4},
		{OP_FETCH, EX_MISS, 32'h0000_00a4},
		{OP_FETCH, EX_MISS, 32'h0000_04a4},
		{OP_FETCH, EX_MISS, 32'h0000_08a4},
		{OP_FETCH, EX_MISS, 32'h0000_0ca4},
		{OP_FETCH, EX_MISS, 32'h0000_10a4},
		// victim choice decides which of these still hit
		{OP_FETCH, EX_ANY, 32'h0000_00a4},
		{OP_FETCH, EX_ANY, 32'h0000_04a4},
		{OP_FETCH, EX_ANY, 32'h0000_08a4},
		{OP_FETCH, EX_ANY, 32'h0000_0ca4},
		{OP_FETCH, EX_ANY, 32'h0000_10a4}
	};

	logic clk;
	logic rst;
	logic req_valid;
	logic [ADDR_W-1:0] req_addr;
	logic flush;
	logic resp_valid;
	logic [31:0] resp_inst;
	logic st_valid;
	logic [ADDR_W-1:0] st_addr;
	logic [31:0] st_data;

	// last word written to each memory location
	logic [31:0] model_mem [MEM_WORDS];
	int n_checks = 0;
	int n_errors = 0;

	icache_subsys #(
		.MEM_WORDS(MEM_WORDS),
		.MEM_LATENCY(MEM_LATENCY)
	) u_icache_subsys (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_addr(req_addr),
		.flush(flush),
		.resp_valid(resp_valid),
		.resp_inst(resp_inst),
		.st_valid(st_valid),
		.st_addr(st_addr),
		.st_data(st_data)
	);

	always #CLK_HALF clk = ~clk;

	// one-cycle store, memory and model updated together
	task automatic store_word(input logic [31:0] addr, input logic [31:0] data);
		@(posedge clk);
		st_valid <= 1'b1;
		st_addr <= addr;
		st_data <= data;
		@(posedge clk);
		st_valid <= 1'b0;
		model_mem[addr[2 +: MEM_AW]] = data;
	endtask

	// single-cycle request pulses until resp_valid shows up
	// a pulse during refill is ignored by the cache, so it just tries again
	task automatic fetch_word(input logic [31:0] addr, input logic with_flush,
			output logic answered, output int tries, output logic [31:0] inst);
		answered = 1'b0;
		tries = 0;
		inst = '0;
		while (!answered && (tries < MAX_TRIES)) begin
			@(posedge clk);
			req_valid <= 1'b1;
			req_addr <= addr;
			flush <= with_flush;
			@(posedge clk);
			req_valid <= 1'b0;
			flush <= 1'b0;
			// registered answer of the lookup taken one edge earlier
			@(posedge clk);
			tries++;
			answered = resp_valid;
			inst = resp_inst;
			if (with_flush) begin
				break;
			end
		end
	endtask

	initial begin
		logic [1:0] op;
		logic [1:0] ex;
		logic [31:0] addr;
		logic [31:0] data;
		logic answered;
		int tries;
		logic [31:0] inst;

		void'($urandom(32'he1d5));
		clk = 1'b0;
		rst = 1'b1;
		req_valid = 1'b0;
		req_addr = '0;
		flush = 1'b0;
		st_valid = 1'b0;
		st_addr = '0;
		st_data = '0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		// idle after reset, nothing may answer
		repeat (4) begin
			@(posedge clk);
			n_checks++;
			assert (!resp_valid) else begin
				$display("[ERROR] resp_valid after reset: got %h expected %h", resp_valid, 1'b0);
				n_errors++;
			end
		end

		for (int i = 0; i < N_OPS; i++) begin
			{op, ex, addr} = OPS[i];
			if (op == OP_STORE) begin
				data = $urandom;
				store_word(addr, data);
			end else if (op == OP_FLUSH) begin
				fetch_word(addr, 1'b1, answered, tries, inst);
				n_checks++;
				assert (!answered) else begin
					$display("[ERROR] resp_valid after flush at %h: got %h expected %h",
						addr, answered, 1'b0);
					n_errors++;
				end
			end else begin
				fetch_word(addr, 1'b0, answered, tries, inst);
				n_checks++;
				assert (answered) else begin
					$display("fetch at %h got no response after %0d tries", addr, tries);
					n_errors++;
				end
				if (answered) begin
					n_checks++;
					assert (inst === model_mem[addr[2 +: MEM_AW]]) else begin
						$display("[ERROR] resp_inst at %h: got %h expected %h",
							addr, inst, model_mem[addr[2 +: MEM_AW]]);
						n_errors++;
					end
					// a hit answers on the first pulse, a miss needs a refill first
					if (ex == EX_HIT) begin
						n_checks++;
						assert (tries == 1) else begin
							$display("fetch at %h missed where a hit was expected", addr);
							n_errors++;
						end
					end else if (ex == EX_MISS) begin
						n_checks++;
						assert (tries > 1) else begin
							$display("fetch at %h hit where a miss was expected", addr);
							n_errors++;
						end
					end
				end
			end
		end

		repeat (2) @(posedge clk);
		$display("%0d checks, %0d errors, %0d assertion failures", n_checks, n_errors,
			u_icache_subsys.u_icache_sva.fail_count);
		if ((n_errors == 0) && (u_icache_subsys.u_icache_sva.fail_count == 0)) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// stops a run that hangs on a lost response
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout, the operation table did not finish in %0d cycles", WATCHDOG_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/icache_sva.sv
`timescale 1ns/1ps
`default_nettype none

module icache_sva (
	input logic clk,
	input logic rst,
	input logic flush,
	input logic resp_valid,
	input logic arvalid,
	input logic arready,
	input logic rvalid,
	input logic rlast
);

	// failed assertions so far
	int unsigned fail_count = 0;
	// address accepted, last beat not yet seen
	logic burst_open;

	always_ff @(posedge clk) begin
		if (rst) begin
			burst_open <= 1'b0;
		end else if (arvalid && arready) begin
			burst_open <= 1'b1;
		end else if (rvalid && rlast) begin
			burst_open <= 1'b0;
		end
	end

	// address request held until the memory takes it
	ar_hold: assert property (@(posedge clk) disable iff (rst)
		(arvalid && !arready) |=> arvalid)
		else begin
			$error("arvalid dropped before arready");
			fail_count++;
		end

	// beats only belong to an accepted burst
	r_after_ar: assert property (@(posedge clk) disable iff (rst)
		rvalid |-> burst_open)
		else begin
			$error("rvalid without an accepted read address");
			fail_count++;
		end

	resp_after_rst: assert property (@(posedge clk)
		rst |=> !resp_valid)
		else begin
			$error("resp_valid high in the cycle after reset");
			fail_count++;
		end

	resp_after_flush: assert property (@(posedge clk) disable iff (rst)
		flush |=> !resp_valid)
		else begin
			$error("resp_valid high in the cycle after flush");
			fail_count++;
		end

	// each answer is a single-cycle pulse
	resp_pulse: assert property (@(posedge clk) disable iff (rst)
		resp_valid |=> !resp_valid)
		else begin
			$error("resp_valid high for more than one cycle");
			fail_count++;
		end

endmodule

bind icache_subsys icache_sva u_icache_sva (
	.clk(clk),
	.rst(rst),
	.flush(flush),
	.resp_valid(resp_valid),
	.arvalid(bus.arvalid),
	.arready(bus.arready),
	.rvalid(bus.rvalid),
	.rlast(bus.rlast)
);

`default_nettype wire

// File: src/icache_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module icache_subsys #(
	parameter int MEM_WORDS = 1024,
	parameter int MEM_LATENCY = 3
) (
	input logic clk,
	input logic rst,
	// fetch side
	input logic req_valid,
	input logic [icache_pkg::ADDR_W-1:0] req_addr,
	input logic flush,
	output logic resp_valid,
	output logic [31:0] resp_inst,
	// store side
	input logic st_valid,
	input logic [icache_pkg::ADDR_W-1:0] st_addr,
	input logic [31:0] st_data
);

	// refill bus between cache and memory
	axi_rd_if bus ();

	// stores also invalidate any cached copy of the line
	icache u_icache (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_addr(req_addr),
		.flush(flush),
		.resp_valid(resp_valid),
		.resp_inst(resp_inst),
		.inval_valid(st_valid),
		.inval_addr(st_addr),
		.bus(bus.master)
	);

	axi_burst_mem #(
		.MEM_WORDS(MEM_WORDS),
		.MEM_LATENCY(MEM_LATENCY)
	) u_mem (
		.clk(clk),
		.rst(rst),
		.st_valid(st_valid),
		.st_addr(st_addr),
		.st_data(st_data),
		.bus(bus.slave)
	);

endmodule

`default_nettype wire

// File: src/axi_burst_mem.sv
`timescale 1ns/1ps
`default_nettype none

module axi_burst_mem #(
	parameter int MEM_WORDS = 1024,
	parameter int MEM_LATENCY = 3
) (
	input logic clk,
	input logic rst,
	input logic st_valid,
	input logic [icache_pkg::ADDR_W-1:0] st_addr,
	input logic [31:0] st_data,
	axi_rd_if.slave bus
);
	import icache_pkg::*;

	localparam int MEM_AW = $clog2(MEM_WORDS);
	// lowest address bit of the word index
	localparam int WORD_LSB = OFFSET_W - WORD_SEL_W;
	localparam int LAT_W = $clog2(MEM_LATENCY + 1);

	localparam logic [1:0] M_IDLE = 2'd0;
	localparam logic [1:0] M_WAIT = 2'd1;
	localparam logic [1:0] M_BEAT = 2'd2;

	logic [31:0] mem [MEM_WORDS];
	logic [1:0] state;
	logic [LAT_W-1:0] lat_cnt;
	logic [WORD_SEL_W-1:0] beat_cnt;
	logic [MEM_AW-1:0] line_base;
	logic [MEM_AW-1:0] rd_idx;

	// store port, word addressed
	always_ff @(posedge clk) begin
		if (st_valid) begin
			mem[st_addr[WORD_LSB +: MEM_AW]] <= st_data;
		end
	end

	// first word of the accepted line
	always_ff @(posedge clk) begin
		if ((state == M_IDLE) && bus.arvalid) begin
			line_base <= bus.araddr[WORD_LSB +: MEM_AW];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= M_IDLE;
			lat_cnt <= '0;
			beat_cnt <= '0;
		end else begin
			case (state)
				M_IDLE: begin
					// one address at a time
					if (bus.arvalid) begin
						lat_cnt <= LAT_W'(MEM_LATENCY - 1);
						state <= M_WAIT;
					end
				end
				M_WAIT: begin
					if (lat_cnt == '0) begin
						beat_cnt <= '0;
						state <= M_BEAT;
					end else begin
						lat_cnt <= lat_cnt - 1'b1;
					end
				end
				M_BEAT: begin
					// four beats back to back, then free again
					beat_cnt <= beat_cnt + 1'b1;
					if (bus.rlast) begin
						state <= M_IDLE;
					end
				end
				default: state <= M_IDLE;
			endcase
		end
	end

	assign bus.arready = (state == M_IDLE);
	assign bus.rvalid = (state == M_BEAT);
	assign bus.rlast = bus.rvalid && (beat_cnt == WORD_SEL_W'(WORDS_PER_LINE - 1));

	assign rd_idx = line_base + MEM_AW'(beat_cnt);
	assign bus.rdata = mem[rd_idx];

endmodule

`default_nettype wire

// File: src/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache (
	input logic clk,
	input logic rst,
	input logic req_valid,
	input logic [icache_pkg::ADDR_W-1:0] req_addr,
	input logic flush,
	output logic resp_valid,
	output logic [31:0] resp_inst,
	input logic inval_valid,
	input logic [icache_pkg::ADDR_W-1:0] inval_addr,
	axi_rd_if.master bus
);
	import icache_pkg::*;

	localparam logic ST_IDLE = 1'b0;
	localparam logic ST_REFILL = 1'b1;

	logic state, state_next;
	logic [WAYS-1:0] hit_way;
	logic lookup_hit;
	logic [WAYS-1:0] victim;
	logic [WORDS_PER_LINE-1:0] beat_sel;
	logic [ADDR_W-1:0] refill_addr;
	logic beat_fire;
	logic fill_done;
	logic [INDEX_W-1:0] way_index;
	logic [WAYS-1:0] way_en;
	logic [WORDS_PER_LINE-1:0] way_word_we;
	icache_line_u fill_line;
	icache_line_u way_rdata [WAYS];
	icache_line_u sel_line;
	logic [WAYS-1:0] hit_way_q;
	logic [WORD_SEL_W-1:0] word_sel_q;

	icache_tag_array u_tag_array (
		.clk(clk),
		.rst(rst),
		.lookup_addr(req_addr),
		.hit_way(hit_way),
		.fill_valid(fill_done),
		.fill_way(victim),
		.fill_addr(refill_addr),
		.inval_valid(inval_valid),
		.inval_addr(inval_addr)
	);

	assign lookup_hit = |hit_way;

	// miss request goes out in the same cycle as the lookup
	assign bus.arvalid = (state == ST_IDLE) && req_valid && !lookup_hit;
	assign bus.araddr = {req_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

	assign beat_fire = (state == ST_REFILL) && bus.rvalid;
	assign fill_done = beat_fire && bus.rlast;

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: if (bus.arvalid && bus.arready) state_next = ST_REFILL;
			ST_REFILL: if (fill_done) state_next = ST_IDLE;
			default: state_next = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			victim <= {{(WAYS-1){1'b0}}, 1'b1};
			beat_sel <= {{(WORDS_PER_LINE-1){1'b0}}, 1'b1};
		end else begin
			state <= state_next;
			if (state == ST_IDLE) begin
				// victim only moves while nothing is being filled
				victim <= {victim[WAYS-2:0], victim[WAYS-1]};
				beat_sel <= {{(WORDS_PER_LINE-1){1'b0}}, 1'b1};
			end else if (beat_fire) begin
				// beats arrive in word order 0 to 3
				beat_sel <= {beat_sel[WORDS_PER_LINE-2:0], beat_sel[WORDS_PER_LINE-1]};
			end
		end
	end

	// line address of the burst in flight
	always_ff @(posedge clk) begin
		if (bus.arvalid && bus.arready) begin
			refill_addr <= bus.araddr;
		end
	end

	// lookup index in idle, refill index while filling
	assign way_index = (state == ST_IDLE) ? req_addr[OFFSET_W +: INDEX_W]
		: refill_addr[OFFSET_W +: INDEX_W];
	assign way_word_we = beat_fire ? beat_sel : '0;

	// every word lane carries the beat, word_we picks the one written
	assign fill_line.flat = {WORDS_PER_LINE{bus.rdata}};

	for (genvar w = 0; w < WAYS; w++) begin : g_way
		// hit way is read in idle, victim way is written during refill
		assign way_en[w] = (state == ST_IDLE) ? (req_valid && hit_way[w])
			: (beat_fire && victim[w]);

		icache_data_way u_data_way (
			.clk(clk),
			.en(way_en[w]),
			.addr(way_index),
			.word_we(way_word_we),
			.wdata(fill_line),
			.rdata(way_rdata[w])
		);
	end

	// response one cycle after a hitting lookup, flush cancels it
	always_ff @(posedge clk) begin
		if (rst) begin
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= (state == ST_IDLE) && req_valid && lookup_hit && !flush;
		end
	end

	// way and word of the answer, kept until the next hit
	always_ff @(posedge clk) begin
		if ((state == ST_IDLE) && req_valid && lookup_hit) begin
			hit_way_q <= hit_way;
			word_sel_q <= req_addr[OFFSET_W-1 -: WORD_SEL_W];
		end
	end

	// one-hot way mux as and-or
	always_comb begin
		sel_line.flat = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (hit_way_q[w]) begin
				sel_line.flat = sel_line.flat | way_rdata[w].flat;
			end
		end
	end

	assign resp_inst = sel_line.words[word_sel_q];

endmodule

`default_nettype wire

// File: src/icache_data_way.sv
`timescale 1ns/1ps
`default_nettype none

module icache_data_way (
	input logic clk,
	input logic en,
	input logic [icache_pkg::INDEX_W-1:0] addr,
	input logic [icache_pkg::WORDS_PER_LINE-1:0] word_we,
	input icache_pkg::icache_line_u wdata,
	output icache_pkg::icache_line_u rdata
);
	import icache_pkg::*;

	// one line per set, stored flat
	logic [WORDS_PER_LINE*32-1:0] mem [SETS];

	// single port: read returns the old line when written in the same cycle
	// rdata keeps its value while en is low
	always_ff @(posedge clk) begin
		if (en) begin
			for (int i = 0; i < WORDS_PER_LINE; i++) begin
				if (word_we[i]) begin
					mem[addr][i*32 +: 32] <= wdata.words[i];
				end
			end
			rdata.flat <= mem[addr];
		end
	end

endmodule

`default_nettype wire

// File: src/icache_tag_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tag_array (
	input logic clk,
	input logic rst,
	input logic [icache_pkg::ADDR_W-1:0] lookup_addr,
	output logic [icache_pkg::WAYS-1:0] hit_way,
	input logic fill_valid,
	input logic [icache_pkg::WAYS-1:0] fill_way,
	input logic [icache_pkg::ADDR_W-1:0] fill_addr,
	input logic inval_valid,
	input logic [icache_pkg::ADDR_W-1:0] inval_addr
);
	import icache_pkg::*;

	logic [TAG_W-1:0] tag_mem [WAYS][SETS];
	logic [SETS-1:0] valid_q [WAYS];

	logic [INDEX_W-1:0] lk_index, fl_index, iv_index;
	logic [TAG_W-1:0] lk_tag, fl_tag, iv_tag;

	// field split of the three addresses
	assign lk_index = lookup_addr[OFFSET_W +: INDEX_W];
	assign lk_tag = lookup_addr[ADDR_W-1 -: TAG_W];
	assign fl_index = fill_addr[OFFSET_W +: INDEX_W];
	assign fl_tag = fill_addr[ADDR_W-1 -: TAG_W];
	assign iv_index = inval_addr[OFFSET_W +: INDEX_W];
	assign iv_tag = inval_addr[ADDR_W-1 -: TAG_W];

	// all ways compared in parallel, at most one can match
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			hit_way[w] = valid_q[w][lk_index] && (tag_mem[w][lk_index] == lk_tag);
		end
	end

	// tag is written together with the last refill beat
	always_ff @(posedge clk) begin
		for (int w = 0; w < WAYS; w++) begin
			if (fill_valid && fill_way[w]) begin
				tag_mem[w][fl_index] <= fl_tag;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < WAYS; w++) begin
				valid_q[w] <= '0;
			end
		end else begin
			for (int w = 0; w < WAYS; w++) begin
				// refill completes, line becomes usable
				if (fill_valid && fill_way[w]) begin
					valid_q[w][fl_index] <= 1'b1;
				end
				// store hit drops every copy of the line, wins over fill
				if (inval_valid && (tag_mem[w][iv_index] == iv_tag)) begin
					valid_q[w][iv_index] <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: src/axi_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axi_rd_if;
	import icache_pkg::*;

	// read address channel, line aligned
	logic arvalid;
	logic [ADDR_W-1:0] araddr;
	logic arready;

	// read data channel, four beats per burst
	// no rready since the cache takes every beat
	logic rvalid;
	logic [31:0] rdata;
	logic rlast;

	modport master (
		output arvalid, araddr,
		input arready, rvalid, rdata, rlast
	);

	modport slave (
		input arvalid, araddr,
		output arready, rvalid, rdata, rlast
	);

endinterface

`default_nettype wire

// File: src/icache_pkg.sv
`default_nettype none

package icache_pkg;

	// fetch and store addresses are byte addresses
	localparam int ADDR_W = 32;

	// cache geometry
	localparam int WORDS_PER_LINE = 4;
	localparam int SETS = 64;
	localparam int WAYS = 4;

	// address split: tag | index | word select | byte in word
	localparam int OFFSET_W = 4;
	localparam int INDEX_W = 6;
	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
	localparam int WORD_SEL_W = 2;

	// one cache line
	// flat is the storage view, words is used for merge and instruction select
	typedef union packed {
		logic [WORDS_PER_LINE*32-1:0] flat;
		logic [WORDS_PER_LINE-1:0][31:0] words;
	} icache_line_u;

endpackage

`default_nettype wire
